//--- decodePkg.sv
`default_nettype none

package decodePkg;

    // Datapath and register-index widths
    localparam int xlen         = 32;
    localparam int regAddrWidth = 5;

    // Base opcodes, RV32I
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // Immediate format select, immI is the cleared value
    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSrcT;

    // Write-back source select
    typedef enum logic [1:0] {
        alu     = 2'd0,
        mem     = 2'd1,
        pcPlus4 = 2'd2
    } resultSrcT;

    // One instruction word, viewed per encoding format
    typedef union packed {
        // Register-register
        struct packed {
            logic [6:0]              funct7;
            logic [regAddrWidth-1:0] rs2;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [regAddrWidth-1:0] rd;
            logic [6:0]              opcode;
        } r;
        // Loads, ALU immediates, JALR
        struct packed {
            logic [11:0]             imm;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [regAddrWidth-1:0] rd;
            logic [6:0]              opcode;
        } i;
        // Stores, immediate split around rs2/rs1
        struct packed {
            logic [6:0]              immHi;
            logic [regAddrWidth-1:0] rs2;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [4:0]              immLo;
            logic [6:0]              opcode;
        } s;
        // Branches, offset bits scattered
        struct packed {
            logic                    imm12;
            logic [5:0]              imm10to5;
            logic [regAddrWidth-1:0] rs2;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [3:0]              imm4to1;
            logic                    imm11;
            logic [6:0]              opcode;
        } b;
        // JAL, 20-bit offset in swizzled order
        struct packed {
            logic                    imm20;
            logic [9:0]              imm10to1;
            logic                    imm11;
            logic [7:0]              imm19to12;
            logic [regAddrWidth-1:0] rd;
            logic [6:0]              opcode;
        } j;
    } instrT;

endpackage

`default_nettype wire

//--- decodeBusIf.sv
`timescale 1ns/1ns
`default_nettype none

interface decodeBus;
    import decodePkg::*;

    // Registered decode-stage fields
    instrT           instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcPlus4;
    // Prediction made in fetch, checked here
    logic [xlen-1:0] predTarget;
    logic            predTaken;
    // Low for a reset or flushed slot
    logic            valid;

    // Pipeline register drives every field
    modport regSide (
        output instr, pc, pcPlus4, predTarget, predTaken, valid
    );

    // Decode logic only looks
    modport readSide (
        input  instr, pc, pcPlus4, predTarget, predTaken, valid
    );

endinterface

`default_nettype wire

//--- decodeReg.sv
`timescale 1ns/1ns
`default_nettype none

module decodeReg (
    input  logic                       clk,
    input  logic                       rstN,
    // Pipeline control, plain levels
    input  logic                       stall,
    input  logic                       flush,
    // Fetch bundle
    input  decodePkg::instrT           instrF,
    input  logic [decodePkg::xlen-1:0] pcF,
    input  logic [decodePkg::xlen-1:0] pcPlus4F,
    input  logic [decodePkg::xlen-1:0] predTargetF,
    input  logic                       predTakenF,
    // Registered stage fields
    decodeBus.regSide                  bus
);

    // Reset and flush beat stall
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            // Empty slot, zero payload too so nothing leaks downstream
            bus.instr      <= '0;
            bus.pc         <= '0;
            bus.pcPlus4    <= '0;
            bus.predTarget <= '0;
            bus.predTaken  <= 1'b0;
            bus.valid      <= 1'b0;
        end else if (!stall) begin
            // Normal load
            bus.instr      <= instrF;
            bus.pc         <= pcF;
            bus.pcPlus4    <= pcPlus4F;
            bus.predTarget <= predTargetF;
            bus.predTaken  <= predTakenF;
            // Every load is a live instruction
            bus.valid      <= 1'b1;
        end
        // Stall high and no flush, everything holds
    end

    // Flushed slot must never reach decode as live, stall or not
    flushKillsSlot: assert property (
        @(posedge clk) flush |=> !bus.valid
    ) else $error("decodeReg: valid high one cycle after flush");

endmodule

`default_nettype wire

//--- immExtend.sv
`timescale 1ns/1ns
`default_nettype none

module immExtend (
    // Registered instruction
    decodeBus.readSide                  bus,
    // Format from the control decoder
    input  decodePkg::immSrcT           immSrc,
    // Sign-extended immediate
    output logic [decodePkg::xlen-1:0]  immExt
);
    import decodePkg::*;

    // Sign bit is bit 31 for every format
    logic signBit;

    assign signBit = bus.instr.r.funct7[6];

    always_comb begin
        case (immSrc)
            immI: begin
                // 12-bit immediate in the top bits
                immExt = {{20{signBit}}, bus.instr.i.imm};
            end
            immS: begin
                // Store offset rejoined from two pieces
                immExt = {{20{signBit}}, bus.instr.s.immHi, bus.instr.s.immLo};
            end
            immB: begin
                // Halfword offset, bit 0 always zero
                immExt = {{19{signBit}},
                          bus.instr.b.imm12,
                          bus.instr.b.imm11,
                          bus.instr.b.imm10to5,
                          bus.instr.b.imm4to1,
                          1'b0};
            end
            immU: begin
                // Upper 20 bits, low 12 cleared
                immExt = {bus.instr[xlen-1:12], 12'b0};
            end
            immJ: begin
                // JAL offset, 21 bits before extension
                immExt = {{11{signBit}},
                          bus.instr.j.imm20,
                          bus.instr.j.imm19to12,
                          bus.instr.j.imm11,
                          bus.instr.j.imm10to1,
                          1'b0};
            end
            default: begin
                // Unused format codes
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- controlDecode.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecode (
    // Registered instruction and valid
    decodeBus.readSide               bus,
    // Immediate format for immExtend
    output decodePkg::immSrcT        immSrc,
    // Datapath controls
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     aluSrc,
    // Flow-change kinds
    output logic                     isBranch,
    output logic                     isJal,
    output logic                     isJalr,
    output logic                     isFlow,
    // Write-back select
    output decodePkg::resultSrcT     resultSrc,
    output logic                     illegal
);
    import decodePkg::*;

    // Fields shared by all formats
    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = bus.instr.r.opcode;
    assign funct3 = bus.instr.r.funct3;

    always_comb begin
        // Defaults, also the empty-slot values
        immSrc    = immI;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        resultSrc = alu;
        illegal   = 1'b0;

        if (bus.valid) begin
            case (opcode)
                opLoad: begin
                    regWrite  = 1'b1;
                    aluSrc    = 1'b1;
                    resultSrc = mem;
                    // LB LH LW LBU LHU only
                    illegal   = (funct3 == 3'd3) || (funct3 >= 3'd6);
                end
                opStore: begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSrc   = immS;
                    // SB SH SW only
                    illegal  = (funct3 > 3'd2);
                end
                opOpImm: begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                end
                opOp: begin
                    regWrite = 1'b1;
                end
                opLui, opAuipc: begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    immSrc   = immU;
                end
                opBranch: begin
                    isBranch = 1'b1;
                    immSrc   = immB;
                    // funct3 2 and 3 unassigned
                    illegal  = (funct3 == 3'd2) || (funct3 == 3'd3);
                end
                opJal: begin
                    regWrite  = 1'b1;
                    isJal     = 1'b1;
                    immSrc    = immJ;
                    resultSrc = pcPlus4;
                end
                opJalr: begin
                    regWrite  = 1'b1;
                    isJalr    = 1'b1;
                    aluSrc    = 1'b1;
                    resultSrc = pcPlus4;
                    illegal   = (funct3 != 3'd0);
                end
                default: begin
                    // Not an RV32I base opcode
                    illegal = 1'b1;
                end
            endcase
        end

        // Flow kinds are exclusive
        flowOneHot: assert ($onehot0({isBranch, isJal, isJalr}))
            else $error("controlDecode: more than one flow kind decoded");
    end

    // Any flow change, used to vet predictions
    assign isFlow = isBranch | isJal | isJalr;

endmodule

`default_nettype wire

//--- jumpResolve.sv
`timescale 1ns/1ns
`default_nettype none

module jumpResolve (
    // pc, pcPlus4 and prediction from the register
    decodeBus.readSide                 bus,
    // J-format offset when isJal is set
    input  logic [decodePkg::xlen-1:0] immExt,
    input  logic                       isJal,
    input  logic                       isFlow,
    // Front-end correction
    output logic                       redirect,
    output logic [decodePkg::xlen-1:0] redirectPc
);
    import decodePkg::*;

    // JAL destination
    logic [xlen-1:0] jalTarget;
    // Prediction checks
    logic            jalMispredict;
    logic            falseTaken;

    assign jalTarget = bus.pc + immExt;

    // JAL wrong if not predicted taken or target differs
    assign jalMispredict = isJal && (!bus.predTaken || (bus.predTarget != jalTarget));

    // Predicted taken on something that cannot branch
    assign falseTaken = bus.valid && !isFlow && bus.predTaken;

    always_comb begin
        // Default shows the jump target with no redirect
        redirect   = 1'b0;
        redirectPc = jalTarget;

        if (isJal) begin
            redirect = jalMispredict;
        end else if (falseTaken) begin
            // Undo the bogus fetch, fall through
            redirect   = 1'b1;
            redirectPc = bus.pcPlus4;
        end
        // Branch and JALR predictions checked later, never here

        // Empty slot must never steer fetch
        redirectNeedsValid: assert (!redirect || bus.valid)
            else $error("jumpResolve: redirect from an invalid slot");
    end

endmodule

`default_nettype wire

//--- decodeTop.sv
`timescale 1ns/1ns
`default_nettype none

module decodeTop (
    input  logic                               clk,
    input  logic                               rstN,
    // Pipeline control
    input  logic                               stall,
    input  logic                               flush,
    // Fetch stage
    input  decodePkg::instrT                   instrF,
    input  logic [decodePkg::xlen-1:0]         pcF,
    input  logic [decodePkg::xlen-1:0]         pcPlus4F,
    input  logic [decodePkg::xlen-1:0]         predTargetF,
    input  logic                               predTakenF,
    // Stage fields
    output logic                               validD,
    output logic [decodePkg::xlen-1:0]         pcD,
    output logic [decodePkg::xlen-1:0]         pcPlus4D,
    // Register indices
    output logic [decodePkg::regAddrWidth-1:0] rdD,
    output logic [decodePkg::regAddrWidth-1:0] rs1D,
    output logic [decodePkg::regAddrWidth-1:0] rs2D,
    // Immediate
    output logic [decodePkg::xlen-1:0]         immExtD,
    output decodePkg::immSrcT                  immSrcD,
    // Controls
    output logic                               regWriteD,
    output logic                               memWriteD,
    output logic                               aluSrcD,
    output decodePkg::resultSrcT               resultSrcD,
    output logic                               isBranchD,
    output logic                               isJalrD,
    output logic                               illegalD,
    // Decode-stage redirect
    output logic                               redirectD,
    output logic [decodePkg::xlen-1:0]         redirectPcD
);
    import decodePkg::*;

    // Between sub-blocks
    immSrcT          immSrc;
    logic [xlen-1:0] immExt;
    logic            isJal;
    logic            isFlow;

    decodeBus bus ();

    decodeReg uDecodeReg (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .flush       (flush),
        .instrF      (instrF),
        .pcF         (pcF),
        .pcPlus4F    (pcPlus4F),
        .predTargetF (predTargetF),
        .predTakenF  (predTakenF),
        .bus         (bus)
    );

    immExtend uImmExtend (
        .bus    (bus),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    controlDecode uControlDecode (
        .bus       (bus),
        .immSrc    (immSrc),
        .regWrite  (regWriteD),
        .memWrite  (memWriteD),
        .aluSrc    (aluSrcD),
        .isBranch  (isBranchD),
        .isJal     (isJal),
        .isJalr    (isJalrD),
        .isFlow    (isFlow),
        .resultSrc (resultSrcD),
        .illegal   (illegalD)
    );

    jumpResolve uJumpResolve (
        .bus        (bus),
        .immExt     (immExt),
        .isJal      (isJal),
        .isFlow     (isFlow),
        .redirect   (redirectD),
        .redirectPc (redirectPcD)
    );

    // Straight from the register
    assign validD   = bus.valid;
    assign pcD      = bus.pc;
    assign pcPlus4D = bus.pcPlus4;

    // Index fields sit in the same place in every format
    assign rdD  = bus.instr.r.rd;
    assign rs1D = bus.instr.r.rs1;
    assign rs2D = bus.instr.r.rs2;

    assign immExtD = immExt;
    assign immSrcD = immSrc;

endmodule

`default_nettype wire

//--- tbDecodeTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbDecodeTop;
    import decodePkg::*;

    localparam int numCycles    = 3000;
    localparam int validTimeout = 8;
    localparam int endTimeout   = numCycles + 200;

    // DUT inputs
    logic        clk = 1'b0;
    logic        rstN;
    logic        stall;
    logic        flush;
    instrT       instrF;
    logic [31:0] pcF;
    logic [31:0] pcPlus4F;
    logic [31:0] predTargetF;
    logic        predTakenF;
    // DUT outputs
    logic        validD;
    logic [31:0] pcD;
    logic [31:0] pcPlus4D;
    logic [4:0]  rdD;
    logic [4:0]  rs1D;
    logic [4:0]  rs2D;
    logic [31:0] immExtD;
    immSrcT      immSrcD;
    logic        regWriteD;
    logic        memWriteD;
    logic        aluSrcD;
    resultSrcT   resultSrcD;
    logic        isBranchD;
    logic        isJalrD;
    logic        illegalD;
    logic        redirectD;
    logic [31:0] redirectPcD;

    // Shadow of the decode register
    logic [31:0] sInstr;
    logic [31:0] sPc;
    logic [31:0] sPcPlus4;
    logic [31:0] sPredTarget;
    logic        sPredTaken;
    logic        sValid;

    logic [31:0] lfsrState    = 32'd30;
    logic        seqDone      = 1'b0;
    int          checkCount   = 0;
    int          errorCount   = 0;
    int          timeoutCount = 0;

    decodeTop u_dut (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit with the low bit taken each time
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return val;
    endfunction

    // Immediate straight from the ISA bit positions
    function automatic logic [31:0] expectedImm(input logic [31:0] w, input logic [2:0] fmt);
        case (fmt)
            immI: return {{20{w[31]}}, w[31:20]};
            immS: return {{20{w[31]}}, w[31:25], w[11:7]};
            immB: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immU: return {w[31:12], 12'd0};
            immJ: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    // Row packs regWrite memWrite aluSrc, resultSrc, immSrc, branch jal jalr, illegal
    function automatic logic [11:0] controlRow(input logic [6:0] op, input logic [2:0] f3);
        case (op)
            opLoad: return {3'b101, 2'd1, immI, 3'b000,
                            !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})};
            opStore: return {3'b011, 2'd0, immS, 3'b000, !(f3 inside {3'd0, 3'd1, 3'd2})};
            opOpImm: return {3'b101, 2'd0, immI, 3'b000, 1'b0};
            opOp: return {3'b100, 2'd0, immI, 3'b000, 1'b0};
            opLui, opAuipc: return {3'b101, 2'd0, immU, 3'b000, 1'b0};
            opBranch: return {3'b000, 2'd0, immB, 3'b100, (f3 inside {3'd2, 3'd3})};
            opJal: return {3'b100, 2'd2, immJ, 3'b010, 1'b0};
            opJalr: return {3'b101, 2'd2, immI, 3'b001, (f3 != 3'd0)};
            default: return {3'b000, 2'd0, immI, 3'b000, 1'b1};
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("error: %s is %h, expected %h at %0t ns", name, got, want, $time);
        end
    endtask

    task automatic checkOutputs();
        logic [11:0] row;
        logic [31:0] imm;
        logic [31:0] target;
        logic        redirect;
        logic [31:0] redirectPc;
        // Empty slot decodes to all zero controls
        row = sValid ? controlRow(sInstr[6:0], sInstr[14:12]) : 12'd0;
        imm = expectedImm(sInstr, row[6:4]);
        target = sPc + imm;
        redirect = 1'b0;
        redirectPc = target;
        if (row[2]) begin
            // JAL resolved here
            redirect = !sPredTaken || (sPredTarget != target);
        end else if (sValid && row[3:1] == 3'b000 && sPredTaken) begin
            redirect = 1'b1;
            redirectPc = sPcPlus4;
        end
        checkValue("validD", 32'(validD), 32'(sValid));
        checkValue("pcD", pcD, sPc);
        checkValue("pcPlus4D", pcPlus4D, sPcPlus4);
        checkValue("rdD", 32'(rdD), 32'(sInstr[11:7]));
        checkValue("rs1D", 32'(rs1D), 32'(sInstr[19:15]));
        checkValue("rs2D", 32'(rs2D), 32'(sInstr[24:20]));
        checkValue("immExtD", immExtD, imm);
        checkValue("immSrcD", 32'(immSrcD), 32'(row[6:4]));
        checkValue("regWriteD", 32'(regWriteD), 32'(row[11]));
        checkValue("memWriteD", 32'(memWriteD), 32'(row[10]));
        checkValue("aluSrcD", 32'(aluSrcD), 32'(row[9]));
        checkValue("resultSrcD", 32'(resultSrcD), 32'(row[8:7]));
        checkValue("isBranchD", 32'(isBranchD), 32'(row[3]));
        checkValue("isJalrD", 32'(isJalrD), 32'(row[1]));
        checkValue("illegalD", 32'(illegalD), 32'(row[0]));
        checkValue("redirectD", 32'(redirectD), 32'(redirect));
        checkValue("redirectPcD", redirectPcD, redirectPc);
    endtask

    // Mostly legal opcodes, extra JALs, some raw words
    task automatic driveRandom();
        logic [31:0] sel;
        logic [31:0] body;
        logic [31:0] rnd;
        logic [6:0]  op;
        sel = randBits(4);
        body = randBits(25);
        case (sel)
            32'd0: op = opLoad;
            32'd1: op = opStore;
            32'd2: op = opOpImm;
            32'd3: op = opOp;
            32'd4: op = opLui;
            32'd5: op = opAuipc;
            32'd6: op = opBranch;
            32'd7: op = opJalr;
            32'd8, 32'd9, 32'd10, 32'd11: op = opJal;
            default: begin
                rnd = randBits(7);
                op = rnd[6:0];
            end
        endcase
        instrF = {body[24:0], op};
        rnd = randBits(30);
        pcF = {rnd[29:0], 2'b00};
        pcPlus4F = pcF + 32'd4;
        predTakenF = (randBits(1) == 32'd1);
        rnd = randBits(30);
        // Half of the JALs carry the right target
        if (op == opJal && randBits(1) == 32'd1) begin
            predTargetF = pcF + expectedImm(instrF, immJ);
        end else begin
            predTargetF = {rnd[29:0], 2'b00};
        end
        stall = (randBits(3) == 32'd0);
        flush = (randBits(4) == 32'd0);
    endtask

    // Reference register clocked on the same edge as the DUT
    always @(posedge clk) begin
        if (!rstN || flush) begin
            sInstr      <= '0;
            sPc         <= '0;
            sPcPlus4    <= '0;
            sPredTarget <= '0;
            sPredTaken  <= 1'b0;
            sValid      <= 1'b0;
        end else if (!stall) begin
            sInstr      <= instrF;
            sPc         <= pcF;
            sPcPlus4    <= pcPlus4F;
            sPredTarget <= predTargetF;
            sPredTaken  <= predTakenF;
            sValid      <= 1'b1;
        end
    end

    // Outputs settled mid-cycle
    always @(negedge clk) begin
        checkOutputs();
    end

    initial begin
        int n;
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        instrF = '0;
        pcF = '0;
        pcPlus4F = '0;
        predTargetF = '0;
        predTakenF = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        driveRandom();
        stall = 1'b0;
        flush = 1'b0;
        // First live slot after reset
        n = 0;
        while (!validD && n < validTimeout) begin
            @(negedge clk);
            n++;
        end
        if (!validD) begin
            $display("Timeout: decode never showed a valid instruction after reset");
            timeoutCount++;
        end
        for (n = 0; n < numCycles; n++) begin
            @(posedge clk);
            #2;
            driveRandom();
            // Flush must win over stall
            if (n % 50 == 49) begin
                stall = 1'b1;
                flush = 1'b1;
            end
        end
        seqDone = 1'b1;
    end

    initial begin
        int waited;
        waited = 0;
        while (!seqDone && waited < endTimeout) begin
            @(posedge clk);
            waited++;
        end
        if (!seqDone) begin
            $display("Timeout: stimulus sequence did not finish");
            timeoutCount++;
        end
        repeat (2) @(negedge clk);
        #1;
        $display("Checks %0d, value errors %0d, timeouts %0d",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
decodePkg.sv
decodeBusIf.sv
decodeReg.sv
immExtend.sv
controlDecode.sv
jumpResolve.sv
decodeTop.sv
tbDecodeTop.sv

//--- Makefile
# Verilator build and run for the decode-stage testbench
VERILATOR ?= verilator
TOP       ?= tbDecodeTop
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
